//--- Bender.yml
package:
  name: busCpu

sources:
  - target: rtl
    include_dirs:
      - hw
    files:
      - hw/isaPkg.sv
      - hw/datapathPkg.sv
      - hw/decodeIf.sv
      - hw/instrDecode.sv
      - hw/aluExecute.sv
      - hw/regWriteback.sv
      - hw/busDatapath.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/busDatapath_checker.sv
      - test/busDatapathTb.sv

//--- busCpu.f
+incdir+hw
hw/isaPkg.sv
hw/datapathPkg.sv
hw/decodeIf.sv
hw/instrDecode.sv
hw/aluExecute.sv
hw/regWriteback.sv
hw/busDatapath.sv
test/busDatapath_checker.sv
test/busDatapathTb.sv

//--- hw/aluExecute.sv
`timescale 1ns/100ps
`default_nettype none

`include "busCpu_defines.svh"

module aluExecute (
    input  wire logic                  clock,
    input  wire logic                  rstN,
    input  wire logic [`BUS_WIDTH-1:0] busValue,
    input  wire logic                  yIn,
    input  wire logic                  zLowIn,
    input  wire logic                  incPc,
    input  wire datapathPkg::aluOpE    aluOp,
    output logic      [`BUS_WIDTH-1:0] zLow
);

    logic [`BUS_WIDTH-1:0] yReg;
    logic [`BUS_WIDTH-1:0] zReg;
    logic [`BUS_WIDTH-1:0] aluResult;
    logic [`BUS_WIDTH-1:0] zNext;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            yReg <= '0;
        end else if (yIn) begin
            yReg <= busValue; // Holds operand A for the next step
        end
    end

    // Operand B always comes straight off the bus
    always_comb begin
        case (aluOp)
            datapathPkg::aluAdd:  aluResult = yReg + busValue;
            datapathPkg::aluSub:  aluResult = yReg - busValue;
            datapathPkg::aluAnd:  aluResult = yReg & busValue;
            datapathPkg::aluOr:   aluResult = yReg | busValue;
            datapathPkg::aluIncB: aluResult = busValue + `BUS_WIDTH'd1;
            default:              aluResult = '0;
        endcase
    end

    // PC increment path takes over the ALU during fetch
    assign zNext = incPc ? (busValue + `BUS_WIDTH'd1) : aluResult;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            zReg <= '0;
        end else if (zLowIn) begin
            zReg <= zNext;
        end
    end

    assign zLow = zReg;

endmodule

`default_nettype wire

//--- hw/busCpu_defines.svh
`ifndef BUSCPU_DEFINES_SVH
`define BUSCPU_DEFINES_SVH

`define BUS_WIDTH      32 // Data and bus width
`define REG_COUNT      16 // General registers R0..R15
`define REG_IDX_WIDTH  4
`define CONST_WIDTH    19 // Immediate field of IR
`define OPCODE_WIDTH   5

// Instruction word field positions
`define OPCODE_MSB     31
`define OPCODE_LSB     27
`define RA_MSB         26
`define RA_LSB         23
`define RB_MSB         22
`define RB_LSB         19
`define RC_MSB         18
`define RC_LSB         15
`define CONST_MSB      18
`define CONST_LSB      0
`define COND_MSB       20 // Branch condition overlays low bits of rb
`define COND_LSB       19

`endif

//--- hw/busDatapath.sv
`timescale 1ns/100ps
`default_nettype none

`include "busCpu_defines.svh"

module busDatapath (
    input  wire logic                  clock,
    input  wire logic                  rstN,
    input  wire logic                  pcOut,
    input  wire logic                  zLowOut,
    input  wire logic                  mdrOut,
    input  wire logic                  rOut,
    input  wire logic                  baOut,
    input  wire logic                  cSignOut,
    input  wire logic                  marIn,
    input  wire logic                  mdrIn,
    input  wire logic                  mdRead,
    input  wire logic                  pcIn,
    input  wire logic                  irIn,
    input  wire logic                  yIn,
    input  wire logic                  zLowIn,
    input  wire logic                  rIn,
    input  wire logic                  conIn,
    input  wire logic                  incPc,
    input  wire logic                  gra,
    input  wire logic                  grb,
    input  wire logic                  grc,
    input  wire datapathPkg::aluOpE    aluOp,
    input  wire logic [`BUS_WIDTH-1:0] memDataIn,
    output logic      [`BUS_WIDTH-1:0] memAddr,
    output logic      [`BUS_WIDTH-1:0] memDataOut,
    output logic                       conFf,
    output isaPkg::opcodeE             opcode
);

    logic [`BUS_WIDTH-1:0] busValue; // Driven by result only
    logic [`BUS_WIDTH-1:0] zLow;

    decodeIf decBus ();

    instrDecode decode (
        .clock    (clock),
        .rstN     (rstN),
        .busValue (busValue),
        .irIn     (irIn),
        .gra      (gra),
        .grb      (grb),
        .grc      (grc),
        .opcode   (opcode),
        .dec      (decBus.decoder)
    );

    aluExecute execute (
        .clock    (clock),
        .rstN     (rstN),
        .busValue (busValue),
        .yIn      (yIn),
        .zLowIn   (zLowIn),
        .incPc    (incPc),
        .aluOp    (aluOp),
        .zLow     (zLow)
    );

    regWriteback result (
        .clock      (clock),
        .rstN       (rstN),
        .zLow       (zLow),
        .memDataIn  (memDataIn),
        .pcOut      (pcOut),
        .zLowOut    (zLowOut),
        .mdrOut     (mdrOut),
        .rOut       (rOut),
        .baOut      (baOut),
        .cSignOut   (cSignOut),
        .marIn      (marIn),
        .mdrIn      (mdrIn),
        .mdRead     (mdRead),
        .pcIn       (pcIn),
        .rIn        (rIn),
        .conIn      (conIn),
        .dec        (decBus.consumer),
        .busValue   (busValue),
        .memAddr    (memAddr),
        .memDataOut (memDataOut),
        .conFf      (conFf)
    );

endmodule

`default_nettype wire

//--- hw/datapathPkg.sv
`default_nettype none

package datapathPkg;

    // Operation applied to Y and the bus on the way into Z
    typedef enum logic [2:0] {
        aluAdd  = 3'd0, // Also forms branch targets
        aluSub  = 3'd1,
        aluAnd  = 3'd2,
        aluOr   = 3'd3,
        aluIncB = 3'd4  // Bus plus one
    } aluOpE;

    // Which block currently drives the shared bus
    typedef enum logic [2:0] {
        srcNone  = 3'd0,
        srcReg   = 3'd1,
        srcPc    = 3'd2,
        srcMdr   = 3'd3,
        srcZLow  = 3'd4,
        srcConst = 3'd5
    } busSrcE;

endpackage

`default_nettype wire

//--- hw/decodeIf.sv
`timescale 1ns/100ps
`default_nettype none

`include "busCpu_defines.svh"

// Decoded IR fields handed from the decoder to the register side
interface decodeIf;

    logic [`REG_IDX_WIDTH-1:0] regIdx;     // Selected ra, rb or rc
    logic                      regIsZero;  // Selected index is R0
    logic [`BUS_WIDTH-1:0]     constValue; // Sign-extended constant
    isaPkg::condE              cond;

    modport decoder (
        output regIdx, regIsZero, constValue, cond
    );

    modport consumer (
        input regIdx, regIsZero, constValue, cond
    );

endinterface

`default_nettype wire

//--- hw/instrDecode.sv
`timescale 1ns/100ps
`default_nettype none

`include "busCpu_defines.svh"

module instrDecode (
    input  wire logic                  clock,
    input  wire logic                  rstN,
    input  wire logic [`BUS_WIDTH-1:0] busValue,
    input  wire logic                  irIn,
    input  wire logic                  gra,
    input  wire logic                  grb,
    input  wire logic                  grc,
    output isaPkg::opcodeE             opcode,
    decodeIf.decoder                   dec
);

    logic [`BUS_WIDTH-1:0]     ir;
    logic [`REG_IDX_WIDTH-1:0] raField;
    logic [`REG_IDX_WIDTH-1:0] rbField;
    logic [`REG_IDX_WIDTH-1:0] rcField;
    logic [`CONST_WIDTH-1:0]   constField;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            ir <= '0;
        end else if (irIn) begin
            ir <= busValue; // Instruction arrives from MDR over the bus
        end
    end

    assign raField    = ir[`RA_MSB:`RA_LSB];
    assign rbField    = ir[`RB_MSB:`RB_LSB];
    assign rcField    = ir[`RC_MSB:`RC_LSB];
    assign constField = ir[`CONST_MSB:`CONST_LSB];

    assign opcode = isaPkg::opcodeE'(ir[`OPCODE_MSB:`OPCODE_LSB]);

    // Sequencer raises at most one of gra, grb, grc per step
    always_comb begin
        if (gra) begin
            dec.regIdx = raField;
        end else if (grb) begin
            dec.regIdx = rbField;
        end else if (grc) begin
            dec.regIdx = rcField;
        end else begin
            dec.regIdx = '0;
        end
    end

    assign dec.regIsZero = (dec.regIdx == '0);

    assign dec.constValue = {{(`BUS_WIDTH - `CONST_WIDTH){constField[`CONST_WIDTH-1]}},
                             constField};

    assign dec.cond = isaPkg::condE'(ir[`COND_MSB:`COND_LSB]);

endmodule

`default_nettype wire

//--- hw/isaPkg.sv
`default_nettype none

`include "busCpu_defines.svh"

package isaPkg;

    // Opcode field of the instruction word
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        opLoad   = 5'b00000,
        opStore  = 5'b00010,
        opAdd    = 5'b00011,
        opSub    = 5'b00100,
        opAnd    = 5'b01001,
        opOr     = 5'b01010,
        opAddi   = 5'b01011,
        opAndi   = 5'b01100,
        opOri    = 5'b01101,
        opBranch = 5'b10010,
        opJump   = 5'b10011,
        opNop    = 5'b11001
    } opcodeE;

    // Branch condition, IR bits 20..19
    typedef enum logic [1:0] {
        brZero     = 2'b00,
        brNonZero  = 2'b01,
        brPositive = 2'b10,
        brNegative = 2'b11
    } condE;

endpackage

`default_nettype wire

//--- hw/regWriteback.sv
`timescale 1ns/100ps
`default_nettype none

`include "busCpu_defines.svh"

module regWriteback (
    input  wire logic                  clock,
    input  wire logic                  rstN,
    input  wire logic [`BUS_WIDTH-1:0] zLow,
    input  wire logic [`BUS_WIDTH-1:0] memDataIn,
    input  wire logic                  pcOut,
    input  wire logic                  zLowOut,
    input  wire logic                  mdrOut,
    input  wire logic                  rOut,
    input  wire logic                  baOut,
    input  wire logic                  cSignOut,
    input  wire logic                  marIn,
    input  wire logic                  mdrIn,
    input  wire logic                  mdRead,
    input  wire logic                  pcIn,
    input  wire logic                  rIn,
    input  wire logic                  conIn,
    decodeIf.consumer                  dec,
    output logic      [`BUS_WIDTH-1:0] busValue,
    output logic      [`BUS_WIDTH-1:0] memAddr,
    output logic      [`BUS_WIDTH-1:0] memDataOut,
    output logic                       conFf
);

    logic [`BUS_WIDTH-1:0] regFile [`REG_COUNT];
    logic [`BUS_WIDTH-1:0] pc;
    logic [`BUS_WIDTH-1:0] mar;
    logic [`BUS_WIDTH-1:0] mdr;
    logic [`BUS_WIDTH-1:0] regRead;
    logic                  condMet;
    datapathPkg::busSrcE   busSrc;

    // One source per step, priority only matters on a sequencer fault
    always_comb begin
        if (pcOut) begin
            busSrc = datapathPkg::srcPc;
        end else if (zLowOut) begin
            busSrc = datapathPkg::srcZLow;
        end else if (mdrOut) begin
            busSrc = datapathPkg::srcMdr;
        end else if (rOut || baOut) begin
            busSrc = datapathPkg::srcReg;
        end else if (cSignOut) begin
            busSrc = datapathPkg::srcConst;
        end else begin
            busSrc = datapathPkg::srcNone;
        end
    end

    // Base-address read treats R0 as constant zero
    assign regRead = (baOut && dec.regIsZero) ? '0 : regFile[dec.regIdx];

    always_comb begin
        case (busSrc)
            datapathPkg::srcReg:   busValue = regRead;
            datapathPkg::srcPc:    busValue = pc;
            datapathPkg::srcMdr:   busValue = mdr;
            datapathPkg::srcZLow:  busValue = zLow;
            datapathPkg::srcConst: busValue = dec.constValue;
            default:               busValue = '0; // Idle bus reads zero
        endcase
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regFile[i] <= '0;
            end
        end else if (rIn) begin
            regFile[dec.regIdx] <= busValue;
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc  <= '0;
            mar <= '0;
            mdr <= '0;
        end else begin
            if (pcIn)  pc  <= busValue;
            if (marIn) mar <= busValue;
            if (mdrIn) mdr <= mdRead ? memDataIn : busValue; // Memory read or bus write
        end
    end

    always_comb begin
        case (dec.cond)
            isaPkg::brZero:     condMet = (busValue == '0);
            isaPkg::brNonZero:  condMet = (busValue != '0);
            isaPkg::brPositive: condMet = !busValue[`BUS_WIDTH-1];
            isaPkg::brNegative: condMet = busValue[`BUS_WIDTH-1];
            default:            condMet = 1'b0;
        endcase
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            conFf <= 1'b0;
        end else if (conIn) begin
            conFf <= condMet;
        end
    end

    assign memAddr    = mar;
    assign memDataOut = mdr;

endmodule

`default_nettype wire

//--- test/busDatapathTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "busCpu_defines.svh"

module busDatapathTb;

    localparam int clockPeriod = 100;
    localparam int resetCycles = 16;
    localparam int maxSteps    = 128;
    localparam int stepWords   = 7; // Columns per pattern line
    localparam int testCount   = 6;

    logic                  clock;
    logic                  rstN;
    logic                  pcOut, zLowOut, mdrOut, rOut, baOut, cSignOut;
    logic                  marIn, mdrIn, mdRead, pcIn, irIn, yIn, zLowIn, rIn, conIn;
    logic                  incPc, gra, grb, grc;
    datapathPkg::aluOpE    aluOp;
    logic [`BUS_WIDTH-1:0] memDataIn;
    logic [`BUS_WIDTH-1:0] memAddr;
    logic [`BUS_WIDTH-1:0] memDataOut;
    logic                  conFf;
    isaPkg::opcodeE        opcode;

    logic [31:0] patMem [0:maxSteps*stepWords-1];
    int          stepIdx;
    int          stepCount;
    int          watchSteps = 0; // Set once the pattern length is known
    int          testIdx;
    int          testErrors;
    int          errorCount;
    int          passCount;
    int          failCount;
    bit          setupError;

    busDatapath i_dut (.*);

    initial clock = 1'b0;
    always #(clockPeriod / 2) clock = ~clock;

    // Control word: strobes in bits 18..0, aluOp in 22..20
    task automatic applyStep(input logic [31:0] control, input logic [31:0] data);
        pcOut     = control[0];
        zLowOut   = control[1];
        mdrOut    = control[2];
        rOut      = control[3];
        baOut     = control[4];
        cSignOut  = control[5];
        marIn     = control[6];
        mdrIn     = control[7];
        mdRead    = control[8];
        pcIn      = control[9];
        irIn      = control[10];
        yIn       = control[11];
        zLowIn    = control[12];
        rIn       = control[13];
        conIn     = control[14];
        incPc     = control[15];
        gra       = control[16];
        grb       = control[17];
        grc       = control[18];
        aluOp     = datapathPkg::aluOpE'(control[22:20]);
        memDataIn = data;
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is %h, expected %h at step %0d",
                     name, actual, expected, stepIdx);
            errorCount++;
            testErrors++;
        end
    endtask

    function automatic string testName(input int idx);
        case (idx)
            0:       return "reset";
            1:       return "fetch";
            2:       return "register zero";
            3:       return "immediate arithmetic";
            4:       return "branch conditions";
            5:       return "branch target";
            default: return "unknown";
        endcase
    endfunction

    task automatic reportTest();
        if (testErrors == 0) begin
            passCount++;
            $display("Test %0d %s: ok", testIdx, testName(testIdx));
        end else begin
            failCount++;
            $display("Test %0d %s: %0d mismatches", testIdx, testName(testIdx), testErrors);
        end
        testIdx++;
        testErrors = 0;
    endtask

    initial begin
        int          base;
        logic [31:0] mask;
        rstN       = 1'b0;
        applyStep('0, '0);
        testIdx    = 0;
        testErrors = 0;
        errorCount = 0;
        passCount  = 0;
        failCount  = 0;
        setupError = 1'b0;
        $readmemh("test/busDatapath_patterns.txt", patMem);
        stepCount = 0;
        while (stepCount < maxSteps && patMem[stepCount * stepWords + 2][5] !== 1'b1) begin
            stepCount++;
        end
        if (stepCount == maxSteps) begin
            $display("Pattern file is missing or has no end marker");
            setupError = 1'b1;
        end else begin
            watchSteps = stepCount;
        end
        repeat (resetCycles) @(negedge clock);
        rstN = 1'b1;
        for (stepIdx = 0; stepIdx < stepCount && !setupError; stepIdx++) begin
            base = stepIdx * stepWords;
            applyStep(patMem[base], patMem[base + 1]);
            @(posedge clock);
            #(clockPeriod * 2 / 5); // Outputs settled, next fall not yet reached
            mask = patMem[base + 2];
            if (mask[0]) checkValue("memAddr", memAddr, patMem[base + 3]);
            if (mask[1]) checkValue("memDataOut", memDataOut, patMem[base + 4]);
            if (mask[2]) checkValue("opcode", opcode, patMem[base + 5]);
            if (mask[3]) checkValue("conFf", conFf, patMem[base + 6]);
            if (mask[4]) reportTest();
            @(negedge clock);
        end
        if (!setupError && testIdx != testCount) begin
            $display("Pattern file ended after %0d of %0d tests", testIdx, testCount);
            setupError = 1'b1;
        end
        $display("Summary: %0d tests ok, %0d tests with mismatches, %0d mismatches in total",
                 passCount, failCount, errorCount);
        if (!setupError && failCount == 0 && errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Two cycles per step leaves ample margin over the single-cycle steps
    initial begin
        wait (watchSteps > 0);
        #((resetCycles + 2 * watchSteps) * clockPeriod);
        $display("Timeout: the run did not finish within %0d clock cycles",
                 resetCycles + 2 * watchSteps);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/busDatapath_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "busCpu_defines.svh"

module busDatapathChecker (
    input wire logic                  clock,
    input wire logic                  rstN,
    input wire logic                  pcOut,
    input wire logic                  zLowOut,
    input wire logic                  mdrOut,
    input wire logic                  rOut,
    input wire logic                  baOut,
    input wire logic                  cSignOut,
    input wire logic                  conIn,
    input wire logic                  conFf,
    input wire logic [`BUS_WIDTH-1:0] memAddr
);

    busOneDriver: assert property (@(posedge clock) disable iff (!rstN)
        $onehot0({pcOut, zLowOut, mdrOut, rOut, baOut, cSignOut}))
        else $error("Several bus source strobes are high in one step");

    resetState: assert property (@(posedge clock)
        !rstN |-> (conFf == 1'b0 && memAddr == '0))
        else $error("conFf or memAddr not cleared while in reset");

    // CON is written only by the step that raises conIn
    conFfHold: assert property (@(posedge clock) disable iff (!rstN)
        $changed(conFf) |-> $past(conIn))
        else $error("conFf changed without conIn in the step before");

endmodule

bind busDatapath busDatapathChecker i_checker (.*);

`default_nettype wire

//--- test/busDatapath_patterns.txt
// control memDataIn mask memAddr memDataOut opcode conFf
// mask bits: 01 memAddr, 02 memDataOut, 04 opcode, 08 conFf, 10 end of test, 20 end of list
// reset
00000000 00000000 1B 00000000 00000000 00 0
// fetch nop at 0, then addi R0,R0,5 at 1
00009041 00000000 01 00000000 00000000 00 0
00000382 C8000000 02 00000000 C8000000 00 0
00000404 00000000 04 00000000 00000000 19 0
00009041 00000000 01 00000001 00000000 00 0
00000382 58000005 02 00000000 58000005 00 0
00000404 00000000 14 00000000 00000000 0B 0
// register zero: R0 = 5, then addi R1,R0,-3 still gives -3
00020810 00000000 00 00000000 00000000 00 0
00001020 00000000 00 00000000 00000000 00 0
00012002 00000000 00 00000000 00000000 00 0
00009041 00000000 01 00000002 00000000 00 0
00000382 5887FFFD 02 00000000 5887FFFD 00 0
00000404 00000000 04 00000000 00000000 0B 0
00020810 00000000 00 00000000 00000000 00 0
00001020 00000000 00 00000000 00000000 00 0
00012002 00000000 00 00000000 00000000 00 0
00010088 00000000 12 00000000 FFFFFFFD 00 0
// immediate arithmetic: addi R2,R1,20 then andi R3,R2,C then ori R4,R3,40001 then st R4,8(R0)
00009041 00000000 01 00000003 00000000 00 0
00000382 59080020 02 00000000 59080020 00 0
00000404 00000000 04 00000000 00000000 0B 0
00020808 00000000 00 00000000 00000000 00 0
00001020 00000000 00 00000000 00000000 00 0
00012002 00000000 00 00000000 00000000 00 0
00010088 00000000 02 00000000 0000001D 00 0
00009041 00000000 01 00000004 00000000 00 0
00000382 6190000C 02 00000000 6190000C 00 0
00000404 00000000 04 00000000 00000000 0C 0
00020808 00000000 00 00000000 00000000 00 0
00201020 00000000 00 00000000 00000000 00 0
00012002 00000000 00 00000000 00000000 00 0
00010088 00000000 02 00000000 0000000C 00 0
00009041 00000000 01 00000005 00000000 00 0
00000382 6A1C0001 02 00000000 6A1C0001 00 0
00000404 00000000 04 00000000 00000000 0D 0
00020808 00000000 00 00000000 00000000 00 0
00301020 00000000 00 00000000 00000000 00 0
00012002 00000000 00 00000000 00000000 00 0
00009041 00000000 01 00000006 00000000 00 0
00000382 12000008 02 00000000 12000008 00 0
00000404 00000000 04 00000000 00000000 02 0
00020810 00000000 00 00000000 00000000 00 0
00001020 00000000 00 00000000 00000000 00 0
00000042 00000000 01 00000008 00000000 00 0
00010088 00000000 13 00000008 FFFC000D 00 0
// branch conditions: each condition on values 0, 11 and 80000004 through MDR
00000180 92800000 00 00000000 00000000 00 0
00000584 00000000 04 00000000 00000000 12 0
00004184 00000011 08 00000000 00000000 00 1
00004184 80000004 08 00000000 00000000 00 0
00004184 92880000 08 00000000 00000000 00 0
00000584 00000000 04 00000000 00000000 12 0
00004184 00000011 08 00000000 00000000 00 0
00004184 80000004 08 00000000 00000000 00 1
00004184 92900000 08 00000000 00000000 00 1
00000584 00000000 04 00000000 00000000 12 0
00004184 00000011 08 00000000 00000000 00 1
00004184 80000004 08 00000000 00000000 00 1
00004184 92980000 08 00000000 00000000 00 0
00000584 00000000 04 00000000 00000000 12 0
00004184 00000011 08 00000000 00000000 00 0
00004184 80000004 08 00000000 00000000 00 0
00004004 00000000 18 00000000 00000000 00 1
// branch target: brnz R2,4 at 7 is taken, brzr R2,4 at C is not
00009041 00000000 01 00000007 00000000 00 0
00000382 91080004 02 00000000 91080004 00 0
00000404 00000000 04 00000000 00000000 12 0
00014008 00000000 08 00000000 00000000 00 1
00000801 00000000 00 00000000 00000000 00 0
00001020 00000000 00 00000000 00000000 00 0
00000202 00000000 00 00000000 00000000 00 0
00000041 00000000 01 0000000C 00000000 00 0
00009041 00000000 01 0000000C 00000000 00 0
00000382 91000004 02 00000000 91000004 00 0
00000404 00000000 04 00000000 00000000 12 0
00014008 00000000 08 00000000 00000000 00 0
00000801 00000000 00 00000000 00000000 00 0
00001020 00000000 00 00000000 00000000 00 0
00000041 00000000 11 0000000D 00000000 00 0
// end of list
00000000 00000000 20 00000000 00000000 00 0
